//--- common/lsu_settings.svh
// global sizes of the load/store unit
// memory port width, queue depth, id width and bus fault codes

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data width of the memory port in bits
`define LSU_MEM_W 32

// in-flight request records held between request and result
`define LSU_QUEUE_DEPTH 4

// instruction id width
`define LSU_ID_W 3

// bus errors map to access fault exceptions
`define LSU_EXC_LOAD_FAULT  6'd5
`define LSU_EXC_STORE_FAULT 6'd7

`endif

//--- common/lsu_pkg.sv
// shared types of the load/store unit
// address and data vectors, element width and stride mode enums

`include "lsu_settings.svh"

package lsu_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // one memory word and its byte enables
    typedef logic [`LSU_MEM_W-1:0]   word_t;
    typedef logic [`LSU_MEM_W/8-1:0] be_t;

    // byte offset inside a word
    typedef logic [1:0] off_t;

    typedef logic [`LSU_ID_W-1:0] id_t;
    typedef logic [5:0]           exccode_t;

    // element width of a vector access
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    // addressing mode where unit stride steps by one word
    typedef enum logic {
        STRIDE_UNIT  = 1'b0,
        STRIDE_CONST = 1'b1
    } stride_e;

endpackage

//--- common/lsu_track_if.sv
// record of one in-flight memory request with valid/ready handshake

interface lsu_track_if import lsu_pkg::*; ();

    logic    valid;
    logic    ready;
    id_t     id;
    logic    first;
    logic    last;
    logic    store;
    stride_e stride;
    eew_e    eew;
    off_t    off;

    modport producer (
        output valid, id, first, last, store, stride, eew, off,
        input  ready
    );

    modport consumer (
        input  valid, id, first, last, store, stride, eew, off,
        output ready
    );

endinterface

//--- lsu/lsu_req_stage.sv
// request stage of the load/store unit
// address generation, store data and byte enables, memory request register

`include "lsu_settings.svh"

module lsu_req_stage import lsu_pkg::*; (
    input  logic    clk_i,
    input  logic    async_rst_ni,

    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  logic    in_first_i,
    input  logic    in_last_i,
    input  id_t     in_id_i,
    input  logic    in_store_i,
    input  stride_e in_stride_i,
    input  eew_e    in_eew_i,
    input  addr_t   in_xval_i,
    input  word_t   in_wdata_i,

    output logic    mem_valid_o,
    input  logic    mem_ready_i,
    output addr_t   mem_addr_o,
    output logic    mem_we_o,
    output be_t     mem_be_o,
    output word_t   mem_wdata_o,

    output logic    done_valid_o,
    output id_t     done_id_o,

    lsu_track_if.producer enq
);

    localparam int unsigned MEM_BYTES = `LSU_MEM_W / 8;

    logic    req_valid_q;
    logic    first_q, last_q, store_q;
    id_t     id_q;
    stride_e stride_q;
    eew_e    eew_q;
    addr_t   addr_q, addr_d;
    word_t   wdata_q, wdata_d;
    be_t     be_q, be_d;
    off_t    off_d;
    logic    mem_accept;

    ////////////////////
    // address and data

    // base on the first beat, then step by a word or by the stride
    always_comb begin
        if (in_first_i) begin
            addr_d = in_xval_i;
        end else if (in_stride_i == STRIDE_UNIT) begin
            addr_d = addr_q + addr_t'(MEM_BYTES);
        end else begin
            addr_d = addr_q + in_xval_i;
        end
    end

    assign off_d = addr_d[1:0];

    always_comb begin
        wdata_d = in_wdata_i;
        be_d    = '0;
        if (in_stride_i == STRIDE_UNIT) begin
            be_d = '1;
        end else begin
            // replicate the element so any enabled lane carries it
            case (in_eew_i)
                EEW_8: begin
                    wdata_d = {MEM_BYTES{in_wdata_i[7:0]}};
                    be_d    = be_t'(1) << off_d;
                end
                EEW_16: begin
                    wdata_d = {(MEM_BYTES / 2){in_wdata_i[15:0]}};
                    be_d    = be_t'(3) << {off_d[1], 1'b0};
                end
                default: begin
                    be_d = '1;
                end
            endcase
        end
        // loads never write
        if (!in_store_i) begin
            be_d = '0;
        end
    end

    ////////////////////
    // request register

    assign mem_accept = mem_valid_o & mem_ready_i;
    assign in_ready_o = ~req_valid_q | mem_accept;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            req_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            req_valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            first_q  <= in_first_i;
            last_q   <= in_last_i;
            id_q     <= in_id_i;
            store_q  <= in_store_i;
            stride_q <= in_stride_i;
            eew_q    <= in_eew_i;
            addr_q   <= addr_d;
            wdata_q  <= wdata_d;
            be_q     <= be_d;
        end
    end

    // hold off the request while the offset queue has no room
    assign mem_valid_o = req_valid_q & enq.ready;
    assign mem_addr_o  = {addr_q[31:2], 2'b00};
    assign mem_we_o    = store_q;
    assign mem_be_o    = be_q;
    assign mem_wdata_o = wdata_q;

    assign done_valid_o = mem_accept & last_q;
    assign done_id_o    = id_q;

    // record goes into the queue together with the accepted request
    assign enq.valid  = req_valid_q & mem_ready_i;
    assign enq.id     = id_q;
    assign enq.first  = first_q;
    assign enq.last   = last_q;
    assign enq.store  = store_q;
    assign enq.stride = stride_q;
    assign enq.eew    = eew_q;
    assign enq.off    = addr_q[1:0];

endmodule

//--- logic/lsu_offset_queue.sv
// circular FIFO of in-flight request records

`include "lsu_settings.svh"

module lsu_offset_queue import lsu_pkg::*; #(
    parameter int unsigned DEPTH = `LSU_QUEUE_DEPTH
) (
    input  logic clk_i,
    input  logic async_rst_ni,

    lsu_track_if.consumer enq,
    lsu_track_if.producer deq
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    typedef struct packed {
        id_t     id;
        logic    first;
        logic    last;
        logic    store;
        stride_e stride;
        eew_e    eew;
        off_t    off;
    } rec_t;

    rec_t             mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_enq, do_deq;
    rec_t             head;

    assign enq.ready = (count_q != CNT_W'(DEPTH));
    assign deq.valid = (count_q != '0);

    assign do_enq = enq.valid & enq.ready;
    assign do_deq = deq.valid & deq.ready;

    always_ff @(posedge clk_i) begin
        if (do_enq) begin
            mem_q[wr_ptr_q] <= '{enq.id, enq.first, enq.last, enq.store,
                                 enq.stride, enq.eew, enq.off};
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign head       = mem_q[rd_ptr_q];
    assign deq.id     = head.id;
    assign deq.first  = head.first;
    assign deq.last   = head.last;
    assign deq.store  = head.store;
    assign deq.stride = head.stride;
    assign deq.eew    = head.eew;
    assign deq.off    = head.off;

endmodule

//--- lsu/lsu_load_align.sv
// result side of the load/store unit
// load element extraction, sticky bus error and completion report

`include "lsu_settings.svh"

module lsu_load_align import lsu_pkg::*; (
    input  logic     clk_i,
    input  logic     async_rst_ni,

    lsu_track_if.consumer deq,

    input  logic     mem_rvalid_i,
    input  word_t    mem_rdata_i,
    input  logic     mem_err_i,

    output logic     out_valid_o,
    output id_t      out_id_o,
    output logic     out_last_o,
    output word_t    out_data_o,

    output logic     cpl_valid_o,
    output id_t      cpl_id_o,
    output logic     cpl_exc_o,
    output exccode_t cpl_exccode_o
);

    logic  err_q, err_d;
    logic  out_valid_q, out_last_q;
    id_t   out_id_q;
    word_t data_q, data_d;
    off_t  shamt;
    word_t shifted;

    // results are in order and cannot wait so every one takes the head
    assign deq.ready = mem_rvalid_i;

    ////////////////////
    // error tracking

    // first result of an instruction starts a fresh error flag
    assign err_d = (deq.first ? 1'b0 : err_q) | mem_err_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            err_q <= 1'b0;
        end else if (mem_rvalid_i) begin
            err_q <= err_d;
        end
    end

    assign cpl_valid_o   = mem_rvalid_i & deq.last;
    assign cpl_id_o      = deq.id;
    assign cpl_exc_o     = err_d;
    assign cpl_exccode_o = deq.store ? `LSU_EXC_STORE_FAULT : `LSU_EXC_LOAD_FAULT;

    ////////////////////
    // load data

    // element offset aligned down to the element size
    always_comb begin
        case (deq.eew)
            EEW_8:   shamt = deq.off;
            EEW_16:  shamt = {deq.off[1], 1'b0};
            default: shamt = '0;
        endcase
        shifted = mem_rdata_i >> {shamt, 3'b000};
        data_d  = mem_rdata_i;
        if (deq.stride == STRIDE_CONST) begin
            case (deq.eew)
                EEW_8:   data_d = word_t'(shifted[7:0]);
                EEW_16:  data_d = word_t'(shifted[15:0]);
                default: data_d = shifted;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= mem_rvalid_i & ~deq.store;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i && !deq.store) begin
            out_id_q   <= deq.id;
            out_last_q <= deq.last;
            data_q     <= data_d;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_id_o    = out_id_q;
    assign out_last_o  = out_last_q;
    assign out_data_o  = data_q;

endmodule

//--- lsu/lsu_top.sv
// top level of the vector load/store unit
// request stage, offset queue and load aligner

module lsu_top import lsu_pkg::*; (
    input  logic     clk_i,
    input  logic     async_rst_ni,

    // issue side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  logic     in_first_i,
    input  logic     in_last_i,
    input  id_t      in_id_i,
    input  logic     in_store_i,
    input  stride_e  in_stride_i,
    input  eew_e     in_eew_i,
    input  addr_t    in_xval_i,
    input  word_t    in_wdata_i,

    // memory port
    output logic     mem_valid_o,
    input  logic     mem_ready_i,
    output addr_t    mem_addr_o,
    output logic     mem_we_o,
    output be_t      mem_be_o,
    output word_t    mem_wdata_o,
    input  logic     mem_rvalid_i,
    input  word_t    mem_rdata_i,
    input  logic     mem_err_i,

    // results and events
    output logic     out_valid_o,
    output id_t      out_id_o,
    output logic     out_last_o,
    output word_t    out_data_o,
    output logic     done_valid_o,
    output id_t      done_id_o,
    output logic     cpl_valid_o,
    output id_t      cpl_id_o,
    output logic     cpl_exc_o,
    output exccode_t cpl_exccode_o
);

    lsu_track_if enq_if ();
    lsu_track_if deq_if ();

    lsu_req_stage u_req (
        .clk_i, .async_rst_ni,
        .in_valid_i, .in_ready_o, .in_first_i, .in_last_i, .in_id_i,
        .in_store_i, .in_stride_i, .in_eew_i, .in_xval_i, .in_wdata_i,
        .mem_valid_o, .mem_ready_i, .mem_addr_o, .mem_we_o, .mem_be_o, .mem_wdata_o,
        .done_valid_o, .done_id_o,
        .enq (enq_if.producer)
    );

    lsu_offset_queue u_queue (
        .clk_i, .async_rst_ni,
        .enq (enq_if.consumer),
        .deq (deq_if.producer)
    );

    lsu_load_align u_align (
        .clk_i, .async_rst_ni,
        .deq (deq_if.consumer),
        .mem_rvalid_i, .mem_rdata_i, .mem_err_i,
        .out_valid_o, .out_id_o, .out_last_o, .out_data_o,
        .cpl_valid_o, .cpl_id_o, .cpl_exc_o, .cpl_exccode_o
    );

endmodule

//--- sim/lsu_mem_model.sv
// memory model for the load/store unit testbench
// byte-addressed storage, random ready, in-order results after 1 to 4 cycles

module lsu_mem_model import lsu_pkg::*; (
    input  logic  clk_i,
    input  logic  async_rst_ni,
    input  logic  mem_valid_i,
    output logic  mem_ready_o,
    input  addr_t mem_addr_i,
    input  logic  mem_we_i,
    input  be_t   mem_be_i,
    input  word_t mem_wdata_i,
    output logic  mem_rvalid_o,
    output word_t mem_rdata_o,
    output logic  mem_err_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t ERR_ADDR = 32'h0000_0F00;

    typedef struct packed {
        word_t       data;
        logic        err;
        int unsigned due;
    } rsp_t;

    logic [7:0]  bytes_q [addr_t];
    rsp_t        rsp_q [$];
    int unsigned cycle = 0;
    int unsigned last_due = 0;

    // unwritten bytes read back a pattern of their address
    function automatic logic [7:0] read_byte(input addr_t a);
        if (bytes_q.exists(a)) begin
            return bytes_q[a];
        end
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
    endfunction

    initial begin
        mem_ready_o  = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        mem_err_o    = 1'b0;
    end

    // a request seen here is taken at the next rising edge
    always @(negedge clk_i) begin
        rsp_t        rsp;
        int unsigned i;
        if (async_rst_ni && mem_valid_i && mem_ready_o) begin
            rsp.err  = (mem_addr_i == ERR_ADDR);
            rsp.data = '0;
            // the faulting word is neither written nor read
            for (i = 0; i < 4; i++) begin
                if (!rsp.err) begin
                    if (mem_we_i && mem_be_i[i]) begin
                        bytes_q[mem_addr_i + i] = mem_wdata_i[8*i +: 8];
                    end
                    rsp.data[8*i +: 8] = read_byte(mem_addr_i + i);
                end
            end
            rsp.due = cycle + 2 + ($urandom % 4);
            if (rsp.due <= last_due) begin
                rsp.due = last_due + 1;
            end
            last_due = rsp.due;
            rsp_q.push_back(rsp);
        end
    end

    always @(posedge clk_i) begin
        logic in_reset;
        // reset level at the edge, where it is stable
        in_reset = !async_rst_ni;
        cycle = cycle + 1;
        #5;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        mem_err_o    = 1'b0;
        if (in_reset) begin
            mem_ready_o = 1'b0;
        end else begin
            mem_ready_o = ($urandom % 4) != 0;
            if (rsp_q.size() != 0 && rsp_q[0].due <= cycle) begin
                mem_rvalid_o = 1'b1;
                mem_rdata_o  = rsp_q[0].data;
                mem_err_o    = rsp_q[0].err;
                void'(rsp_q.pop_front());
            end
        end
    end

endmodule

//--- sim/lsu_tb.sv
// testbench for the load/store unit
// directed instruction sequence, expected-value queues, checks and watchdog

`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_PERIOD      = 40;
    localparam int unsigned RESET_CYCLES    = 4;
    localparam int unsigned TOTAL_BEATS     = 43;
    localparam int unsigned CYCLES_PER_BEAT = 200;
    localparam addr_t       ERR_ADDR        = 32'h0000_0F00;
    localparam logic [31:0] SEED            = 32'h6db9e7a3;

    typedef struct packed {
        addr_t       addr;
        logic        we;
        be_t         be;
        word_t       wdata;
        int unsigned tidx;
    } req_exp_t;

    typedef struct packed {
        id_t         id;
        logic        last;
        word_t       data;
        int unsigned tidx;
    } out_exp_t;

    typedef struct packed {
        id_t         id;
        logic        exc;
        exccode_t    code;
        int unsigned tidx;
    } cpl_exp_t;

    logic clk_i, async_rst_ni;
    logic in_valid_i, in_ready_o, in_first_i, in_last_i, in_store_i;
    id_t in_id_i;
    stride_e in_stride_i;
    eew_e in_eew_i;
    addr_t in_xval_i, mem_addr_o;
    word_t in_wdata_i, mem_wdata_o, mem_rdata_i, out_data_o;
    logic mem_valid_o, mem_ready_i, mem_we_o, mem_rvalid_i, mem_err_i;
    be_t mem_be_o;
    logic out_valid_o, out_last_o, done_valid_o, cpl_valid_o, cpl_exc_o;
    id_t out_id_o, done_id_o, cpl_id_o;
    exccode_t cpl_exccode_o;

    req_exp_t    req_exp_q [$];
    out_exp_t    out_exp_q [$];
    cpl_exp_t    done_exp_q [$];
    cpl_exp_t    cpl_exp_q [$];
    logic [7:0]  shadow [addr_t];
    string       test_names [16];
    int unsigned n_tests = 0;
    int unsigned done_count = 0;
    int unsigned cpl_count = 0;

    // request seen stalled at the last falling edge
    logic  stall_q = 1'b0;
    addr_t held_addr;
    logic  held_we;
    be_t   held_be;
    word_t held_wdata;

    lsu_top dut0 (.*);

    lsu_mem_model mem0 (
        .clk_i, .async_rst_ni,
        .mem_valid_i (mem_valid_o), .mem_ready_o (mem_ready_i),
        .mem_addr_i (mem_addr_o), .mem_we_i (mem_we_o), .mem_be_i (mem_be_o),
        .mem_wdata_i (mem_wdata_o), .mem_rvalid_o (mem_rvalid_i),
        .mem_rdata_o (mem_rdata_i), .mem_err_o (mem_err_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string field, input int unsigned tidx,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        report_failure($sformatf("** Error %s, %s: expected 0x%08h, actual 0x%08h",
                                 test_names[tidx], field, exp_val, act_val));
    endtask

    // queue the expected traffic of one instruction, then issue its beats
    task automatic run_instr(input string name, input id_t id, input logic store,
                             input stride_e stride, input eew_e eew, input addr_t base,
                             input addr_t stride_val, input int unsigned beats);
        addr_t       addr;
        addr_t       word;
        int unsigned elsz, lane, i, b, tidx;
        be_t         be;
        word_t       data, wexp, rword, rexp;
        logic        exc;
        tidx = n_tests;
        test_names[tidx] = name;
        n_tests++;
        exc  = 1'b0;
        addr = base;
        elsz = (stride == STRIDE_UNIT || eew == EEW_32) ? 4 : (eew == EEW_16) ? 2 : 1;
        for (b = 0; b < beats; b++) begin
            if (b != 0) begin
                addr = addr + ((stride == STRIDE_UNIT) ? 32'd4 : stride_val);
            end
            word = {addr[31:2], 2'b00};
            lane = (int'(addr[1:0]) / elsz) * elsz;
            data = $urandom;
            be   = '0;
            wexp = '0;
            for (i = 0; i < 4; i++) begin
                if (i >= lane && i < lane + elsz) begin
                    be[i] = store;
                end
                wexp[8*i +: 8] = data[8*(i % elsz) +: 8];
                if (be[i] && word != ERR_ADDR) begin
                    shadow[word + i] = wexp[8*i +: 8];
                end
            end
            exc = exc | (word == ERR_ADDR);
            req_exp_q.push_back(req_exp_t'{word, store, be, wexp, tidx});
            if (!store) begin
                rword = '0;
                rexp  = '0;
                for (i = 0; i < 4 && word != ERR_ADDR; i++) begin
                    rword[8*i +: 8] = shadow[word + i];
                end
                for (i = 0; i < elsz; i++) begin
                    rexp[8*i +: 8] = rword[8*(lane + i) +: 8];
                end
                out_exp_q.push_back(out_exp_t'{id, b == beats - 1, rexp, tidx});
            end
            if (b == beats - 1) begin
                done_exp_q.push_back(cpl_exp_t'{id, 1'b0, 6'd0, tidx});
                cpl_exp_q.push_back(cpl_exp_t'{id, exc,
                    store ? `LSU_EXC_STORE_FAULT : `LSU_EXC_LOAD_FAULT, tidx});
            end
            in_valid_i  = 1'b1;
            in_first_i  = (b == 0);
            in_last_i   = (b == beats - 1);
            in_id_i     = id;
            in_store_i  = store;
            in_stride_i = stride;
            in_eew_i    = eew;
            in_xval_i   = (b == 0) ? base : stride_val;
            in_wdata_i  = data;
            @(negedge clk_i);
            while (!in_ready_o) @(negedge clk_i);
            @(posedge clk_i);
            #5;
        end
        in_valid_i = 1'b0;
    endtask

    ////////////////////
    // checks

    always @(negedge clk_i) begin
        req_exp_t    r;
        out_exp_t    o;
        cpl_exp_t    c;
        word_t       mask;
        int unsigned i;
        if (async_rst_ni) begin
            if (stall_q) begin
                assert (mem_valid_o) else report_failure("mem_valid_o dropped while stalled");
                assert (mem_addr_o == held_addr)
                    else report_failure("mem_addr_o changed while stalled");
                assert (mem_we_o == held_we && mem_be_o == held_be
                        && mem_wdata_o == held_wdata)
                    else report_failure("request fields changed while stalled");
            end
            stall_q    = mem_valid_o && !mem_ready_i;
            held_addr  = mem_addr_o;
            held_we    = mem_we_o;
            held_be    = mem_be_o;
            held_wdata = mem_wdata_o;
            if (mem_valid_o && mem_ready_i) begin
                assert (req_exp_q.size() != 0) else report_failure("unexpected memory request");
                r = req_exp_q.pop_front();
                // only enabled bytes carry store data
                for (i = 0; i < 4; i++) begin
                    mask[8*i +: 8] = {8{r.be[i]}};
                end
                assert (mem_addr_o == r.addr)
                    else value_error("mem_addr_o", r.tidx, r.addr, mem_addr_o);
                assert (mem_we_o == r.we)
                    else value_error("mem_we_o", r.tidx, 32'(r.we), 32'(mem_we_o));
                assert (mem_be_o == r.be)
                    else value_error("mem_be_o", r.tidx, 32'(r.be), 32'(mem_be_o));
                assert ((mem_wdata_o & mask) == (r.wdata & mask))
                    else value_error("mem_wdata_o", r.tidx, r.wdata & mask, mem_wdata_o & mask);
            end
            if (out_valid_o) begin
                assert (out_exp_q.size() != 0) else report_failure("unexpected load result");
                o = out_exp_q.pop_front();
                assert (out_data_o == o.data)
                    else value_error("out_data_o", o.tidx, o.data, out_data_o);
                assert (out_last_o == o.last)
                    else value_error("out_last_o", o.tidx, 32'(o.last), 32'(out_last_o));
                assert (out_id_o == o.id)
                    else value_error("out_id_o", o.tidx, 32'(o.id), 32'(out_id_o));
            end
            if (done_valid_o) begin
                assert (done_exp_q.size() != 0) else report_failure("done_valid_o fired twice");
                c = done_exp_q.pop_front();
                done_count++;
                assert (done_id_o == c.id)
                    else value_error("done_id_o", c.tidx, 32'(c.id), 32'(done_id_o));
            end
            if (cpl_valid_o) begin
                assert (cpl_exp_q.size() != 0) else report_failure("cpl_valid_o fired twice");
                c = cpl_exp_q.pop_front();
                cpl_count++;
                assert (cpl_id_o == c.id)
                    else value_error("cpl_id_o", c.tidx, 32'(c.id), 32'(cpl_id_o));
                assert (cpl_exc_o == c.exc)
                    else value_error("cpl_exc_o", c.tidx, 32'(c.exc), 32'(cpl_exc_o));
                if (c.exc) begin
                    assert (cpl_exccode_o == c.code)
                        else value_error("cpl_exccode_o", c.tidx, 32'(c.code),
                                         32'(cpl_exccode_o));
                end
            end
        end
    end

    // budget grows with the number of beats in the sequence
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_BEAT * TOTAL_BEATS));
        report_failure("watchdog expired before the test sequence completed");
    end

    initial begin
        void'($urandom(SEED));
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        in_first_i   = 1'b0;
        in_last_i    = 1'b0;
        in_id_i      = '0;
        in_store_i   = 1'b0;
        in_stride_i  = STRIDE_UNIT;
        in_eew_i     = EEW_8;
        in_xval_i    = '0;
        in_wdata_i   = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #5;
        async_rst_ni = 1'b1;
        @(negedge clk_i);
        assert (in_ready_o && !mem_valid_o && !out_valid_o && !done_valid_o && !cpl_valid_o)
            else report_failure("outputs not idle after reset");
        @(posedge clk_i);
        #5;
        run_instr("unit-stride store", 3'd0, 1'b1, STRIDE_UNIT, EEW_32, 32'h102, 32'h0, 4);
        run_instr("unit-stride load", 3'd1, 1'b0, STRIDE_UNIT, EEW_32, 32'h100, 32'h0, 4);
        run_instr("strided store 8", 3'd2, 1'b1, STRIDE_CONST, EEW_8, 32'h201, 32'd5, 6);
        run_instr("strided store 16", 3'd3, 1'b1, STRIDE_CONST, EEW_16, 32'h302, 32'd3, 4);
        run_instr("strided store 32", 3'd4, 1'b1, STRIDE_CONST, EEW_32, 32'h400, 32'd12, 3);
        run_instr("strided load 8", 3'd5, 1'b0, STRIDE_CONST, EEW_8, 32'h201, 32'd5, 6);
        run_instr("strided load 16", 3'd6, 1'b0, STRIDE_CONST, EEW_16, 32'h302, 32'd3, 4);
        run_instr("strided load 32", 3'd7, 1'b0, STRIDE_CONST, EEW_32, 32'h400, 32'd12, 3);
        run_instr("store bus error", 3'd0, 1'b1, STRIDE_UNIT, EEW_32, 32'hEF8, 32'h0, 4);
        run_instr("load bus error", 3'd1, 1'b0, STRIDE_CONST, EEW_16, 32'hEFC, 32'd4, 3);
        run_instr("load after error", 3'd2, 1'b0, STRIDE_UNIT, EEW_32, 32'h100, 32'h0, 2);
        // load results trail their completion by one cycle
        while (cpl_count < n_tests || out_exp_q.size() != 0) @(negedge clk_i);
        if (done_count == n_tests && req_exp_q.size() == 0 && done_exp_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure("done events or memory requests missing at the end of the run");
        end
    end

endmodule

//--- build.f
+incdir+common
common/lsu_pkg.sv
common/lsu_track_if.sv
lsu/lsu_req_stage.sv
logic/lsu_offset_queue.sv
lsu/lsu_load_align.sv
lsu/lsu_top.sv
sim/lsu_mem_model.sv
sim/lsu_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := lsu_tb
LINT_TOP := lsu_top
FLIST    := build.f
OBJ      := obj_dir
PASS     := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee /dev/stderr | grep "$(PASS)" > /dev/null

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/1ps --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ)
